//--- Makefile
# Verilator build and run of the distance unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = distance_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
hw/distance_pkg.sv
hw/fxp_iter_mult.sv
hw/fxp_sqrt.sv
hw/distance_cal.sv
hw/result_fifo.sv
hw/distance_top.sv
testbench/clock_gen.sv
testbench/distance_tb.sv

//--- hw/distance_cal.sv
/*
  sqrt(a^2 + b^2) for unsigned Q16.16 operands; squares and sum wrap at 32 bits.
  Takes one job at a time, about 58 cycles without back-pressure.
*/
`default_nettype none
`timescale 1ns/1ps

module distance_cal (
  input  logic                                clk,
  input  logic                                reset,

  input  logic [distance_pkg::msg_width-1:0]  recv_msg,
  input  logic                                recv_val,
  output logic                                recv_rdy,

  output logic [distance_pkg::data_width-1:0] send_msg,
  output logic                                send_val,
  input  logic                                send_rdy
);

  logic [distance_pkg::data_width-1:0] a;
  logic [distance_pkg::data_width-1:0] b;
  logic [distance_pkg::data_width-1:0] a_squared;
  logic [distance_pkg::data_width-1:0] b_squared;
  logic [distance_pkg::data_width-1:0] square_sum;

  logic a_recv_rdy;
  logic b_recv_rdy;
  logic a_send_val;
  logic b_send_val;
  logic mult_recv_val;
  logic mult_send_rdy;

  logic root_recv_val;
  logic root_recv_rdy;
  logic root_send_val;

  distance_pkg::cal_state_t state;
  distance_pkg::cal_state_t next_state;

  assign a = recv_msg[distance_pkg::msg_width-1 -: distance_pkg::data_width];
  assign b = recv_msg[distance_pkg::data_width-1:0];

  // both squarers start on the same edge
  assign mult_recv_val = recv_val && recv_rdy;

  // ========================================
  // squaring
  // ========================================
  fxp_iter_mult a_square (
    .clk      (clk),
    .reset    (reset),
    .recv_val (mult_recv_val),
    .recv_rdy (a_recv_rdy),
    .a        (a),
    .b        (a),
    .send_val (a_send_val),
    .send_rdy (mult_send_rdy),
    .c        (a_squared)
  );

  fxp_iter_mult b_square (
    .clk      (clk),
    .reset    (reset),
    .recv_val (mult_recv_val),
    .recv_rdy (b_recv_rdy),
    .a        (b),
    .b        (b),
    .send_val (b_send_val),
    .send_rdy (mult_send_rdy),
    .c        (b_squared)
  );

  // wraps modulo 2^32; squarer outputs stay put while idle
  assign square_sum = a_squared + b_squared;

  // ========================================
  // square root
  // ========================================
  fxp_sqrt root (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (square_sum),
    .recv_val (root_recv_val),
    .recv_rdy (root_recv_rdy),
    .send_msg (send_msg),
    .send_val (root_send_val),
    .send_rdy (send_rdy)
  );

  // ========================================
  // phase control
  // ========================================
  always_comb begin
    next_state = state;
    case (state)
      distance_pkg::mult_phase: begin
        if (a_send_val && b_send_val && mult_send_rdy) begin
          next_state = distance_pkg::root_phase;
        end
      end
      distance_pkg::root_phase: begin
        if (root_send_val && send_rdy) begin
          next_state = distance_pkg::mult_phase;
        end
      end
      default: next_state = distance_pkg::mult_phase;
    endcase
  end

  always_comb begin
    recv_rdy      = 1'b0;
    mult_send_rdy = 1'b0;
    root_recv_val = 1'b0;
    send_val      = 1'b0;
    case (state)
      distance_pkg::mult_phase: begin
        recv_rdy      = a_recv_rdy && b_recv_rdy;
        // squares hand over only to a free root stage
        mult_send_rdy = root_recv_rdy;
      end
      distance_pkg::root_phase: begin
        root_recv_val = 1'b1;
        send_val      = root_send_val;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= distance_pkg::mult_phase;
    end else begin
      state <= next_state;
    end
  end

endmodule

`default_nettype wire

//--- hw/distance_pkg.sv
/*
  Shared constants for the distance unit. Operands and results are unsigned
  Q16.16; the packed input pair holds a in the upper half and b in the lower.
*/
`default_nettype none

package distance_pkg;

  // ========================================
  // data format
  // ========================================
  localparam int data_width = 32;
  localparam int frac_bits  = 16;

  // a in the upper half, b in the lower half
  localparam int msg_width  = 2 * data_width;

  // ========================================
  // result queue
  // ========================================
  localparam int fifo_depth = 4;

  // controller phases of one job
  typedef enum logic {
    mult_phase = 1'b0,
    root_phase = 1'b1
  } cal_state_t;

endpackage

`default_nettype wire

//--- hw/distance_top.sv
/*
  Distance unit with its result queue; latency varies with back-pressure.
*/
`default_nettype none
`timescale 1ns/1ps

module distance_top (
  input  logic                                clk,
  input  logic                                reset,

  input  logic [distance_pkg::msg_width-1:0]  recv_msg,
  input  logic                                recv_val,
  output logic                                recv_rdy,

  output logic [distance_pkg::data_width-1:0] send_msg,
  output logic                                send_val,
  input  logic                                send_rdy
);

  logic [distance_pkg::data_width-1:0] cal_send_msg;
  logic                                cal_send_val;
  logic                                cal_send_rdy;

  distance_cal cal (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (cal_send_msg),
    .send_val (cal_send_val),
    .send_rdy (cal_send_rdy)
  );

  result_fifo #(
    .depth (distance_pkg::fifo_depth)
  ) queue (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (cal_send_msg),
    .recv_val (cal_send_val),
    .recv_rdy (cal_send_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy)
  );

endmodule

`default_nettype wire

//--- hw/fxp_iter_mult.sv
/*
  Unsigned fixed-point multiply, one partial product per cycle. The product
  is truncated to data_width bits and wraps on overflow. One job at a time.
*/
`default_nettype none
`timescale 1ns/1ps

module fxp_iter_mult (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                recv_val,
  output logic                                recv_rdy,
  input  logic [distance_pkg::data_width-1:0] a,
  input  logic [distance_pkg::data_width-1:0] b,

  output logic                                send_val,
  input  logic                                send_rdy,
  output logic [distance_pkg::data_width-1:0] c
);

  localparam int prod_width  = 2 * distance_pkg::data_width;
  localparam int count_width = $clog2(distance_pkg::data_width);
  localparam logic [count_width-1:0] last_count = count_width'(distance_pkg::data_width - 1);

  typedef enum logic [1:0] {
    idle,
    busy,
    done
  } mult_state_t;

  mult_state_t state;

  logic [prod_width-1:0]                multiplicand;
  logic [distance_pkg::data_width-1:0]  multiplier;
  logic [prod_width-1:0]                acc;
  logic [count_width-1:0]               count;

  assign recv_rdy = (state == idle);
  assign send_val = (state == done);

  // drop the fraction bits of the full product
  assign c = acc[distance_pkg::frac_bits +: distance_pkg::data_width];

  // ========================================
  // control
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      count <= '0;
    end else begin
      case (state)
        idle: begin
          if (recv_val) begin
            state <= busy;
            count <= '0;
          end
        end
        busy: begin
          count <= count + 1'b1;
          if (count == last_count) begin
            state <= done;
          end
        end
        done: begin
          if (send_rdy) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // ========================================
  // datapath
  // ========================================
  always_ff @(posedge clk) begin
    if (state == idle && recv_val) begin
      multiplicand <= prod_width'(a);
      multiplier   <= b;
      acc          <= '0;
    end else if (state == busy) begin
      // lsb of the multiplier picks this cycle's partial product
      if (multiplier[0]) begin
        acc <= acc + multiplicand;
      end
      multiplicand <= {multiplicand[prod_width-2:0], 1'b0};
      multiplier   <= multiplier >> 1;
    end
  end

endmodule

`default_nettype wire

//--- hw/fxp_sqrt.sv
/*
  Unsigned fixed-point square root by non-restoring digit recurrence.
  Returns floor(sqrt(x * 2^frac_bits)) after (data_width + frac_bits)/2 cycles.
*/
`default_nettype none
`timescale 1ns/1ps

module fxp_sqrt (
  input  logic                                clk,
  input  logic                                reset,

  input  logic [distance_pkg::data_width-1:0] recv_msg,
  input  logic                                recv_val,
  output logic                                recv_rdy,

  output logic [distance_pkg::data_width-1:0] send_msg,
  output logic                                send_val,
  input  logic                                send_rdy
);

  // the radicand carries frac_bits extra zero bits
  localparam int rad_width   = distance_pkg::data_width + distance_pkg::frac_bits;
  localparam int root_width  = rad_width / 2;
  localparam int rem_width   = root_width + 2;
  localparam int pad_width   = distance_pkg::data_width - root_width;
  localparam int count_width = $clog2(root_width);
  localparam logic [count_width-1:0] last_count = count_width'(root_width - 1);

  typedef enum logic [1:0] {
    idle,
    busy,
    done
  } sqrt_state_t;

  sqrt_state_t state;

  logic [rad_width-1:0]   rad;
  logic [rem_width-1:0]   rem;
  logic [root_width-1:0]  root;
  logic [count_width-1:0] count;

  logic [rem_width-1:0]   rem_shift;
  logic [rem_width-1:0]   rem_next;
  logic [root_width-1:0]  root_next;

  assign recv_rdy = (state == idle);
  assign send_val = (state == done);
  assign send_msg = {{pad_width{1'b0}}, root};

  // ========================================
  // one result bit per cycle
  // ========================================
  assign rem_shift = {rem[rem_width-3:0], rad[rad_width-1 -: 2]};

  always_comb begin
    // sign of the remainder picks subtract or add of the trial value
    if (!rem[rem_width-1]) begin
      rem_next = rem_shift - {root, 2'b01};
    end else begin
      rem_next = rem_shift + {root, 2'b11};
    end
  end

  assign root_next = {root[root_width-2:0], ~rem_next[rem_width-1]};

  // ========================================
  // control
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      count <= '0;
    end else begin
      case (state)
        idle: begin
          if (recv_val) begin
            state <= busy;
            count <= '0;
          end
        end
        busy: begin
          count <= count + 1'b1;
          if (count == last_count) begin
            state <= done;
          end
        end
        done: begin
          if (send_rdy) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && recv_val) begin
      rad  <= {recv_msg, {distance_pkg::frac_bits{1'b0}}};
      rem  <= '0;
      root <= '0;
    end else if (state == busy) begin
      rad  <= {rad[rad_width-3:0], 2'b00};
      rem  <= rem_next;
      root <= root_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/result_fifo.sv
/*
  Synchronous result FIFO, depth of 2 or more. Accepts a write while full
  when a read happens on the same edge, so recv_rdy depends on send_rdy.
*/
`default_nettype none
`timescale 1ns/1ps

module result_fifo #(
  parameter int depth = distance_pkg::fifo_depth
) (
  input  logic                                clk,
  input  logic                                reset,

  input  logic [distance_pkg::data_width-1:0] recv_msg,
  input  logic                                recv_val,
  output logic                                recv_rdy,

  output logic [distance_pkg::data_width-1:0] send_msg,
  output logic                                send_val,
  input  logic                                send_rdy
);

  localparam int ptr_width   = $clog2(depth);
  localparam int count_width = $clog2(depth + 1);
  localparam logic [ptr_width-1:0]   last_ptr = ptr_width'(depth - 1);
  localparam logic [count_width-1:0] full_count = count_width'(depth);

  logic [distance_pkg::data_width-1:0] mem [depth];

  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;
  logic                   do_write;
  logic                   do_read;

  assign send_val = (count != '0);
  assign recv_rdy = (count != full_count) || send_rdy;
  assign send_msg = mem[rd_ptr];

  assign do_write = recv_val && recv_rdy;
  assign do_read  = send_val && send_rdy;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= recv_msg;
    end
  end

  // pointers wrap by hand so depth need not be a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
/*
  20 ns clock for the testbench. Reset is high from time zero for 8 rising
  edges and drops 2 ns after the last one, in step with the input drive point.
*/
`default_nettype none
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic reset
);

  localparam int half_period  = 10;
  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2 reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/distance_tb.sv
/*
  Testbench for distance_top. Inputs change 2 ns after the rising edge and all
  handshakes are sampled on the falling edge. Results are checked in order.
*/
`default_nettype none
`timescale 1ns/1ps

module distance_tb;

  localparam int root_bits   = (distance_pkg::data_width + distance_pkg::frac_bits) / 2;
  localparam int bp_jobs     = 40;
  localparam int idle_jobs   = 40;
  localparam int total_jobs  = 4 + 200 + 50 + bp_jobs + idle_jobs;
  localparam int cycle_limit = total_jobs * 80 * 4 + 200;

  logic                                clk;
  logic                                reset;
  logic [distance_pkg::msg_width-1:0]  recv_msg;
  logic                                recv_val;
  logic                                recv_rdy;
  logic [distance_pkg::data_width-1:0] send_msg;
  logic                                send_val;
  logic                                send_rdy;

  // scoreboard queues written only by the falling-edge monitor
  logic [distance_pkg::data_width-1:0] expected_q[$];
  string                               name_q[$];
  logic [distance_pkg::data_width-1:0] pending_expected;
  string                               pending_name;

  int  accepted_count;
  int  received_count;
  int  max_outstanding;
  int  mismatch_errors;
  int  other_errors;
  int  cycle_count;
  bit  stall_mode;

  clock_gen clocks (
    .clk   (clk),
    .reset (reset)
  );

  distance_top uut (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy)
  );

  // ========================================
  // reference model
  // ========================================
  function automatic logic [distance_pkg::data_width-1:0] model_distance(
    input logic [distance_pkg::msg_width-1:0] pair
  );
    logic [63:0]                         a_full;
    logic [63:0]                         b_full;
    logic [distance_pkg::data_width-1:0] sum;
    logic [63:0]                         rad;
    logic [63:0]                         cand;
    logic [root_bits-1:0]                root;
    logic [root_bits-1:0]                bit_mask;
    a_full = {32'b0, pair[63:32]} * {32'b0, pair[63:32]};
    b_full = {32'b0, pair[31:0]} * {32'b0, pair[31:0]};
    sum = 32'(a_full >> distance_pkg::frac_bits) + 32'(b_full >> distance_pkg::frac_bits);
    rad = {16'b0, sum, 16'b0};
    root = '0;
    bit_mask = {1'b1, {(root_bits-1){1'b0}}};
    // bitwise search from the top bit down
    repeat (root_bits) begin
      cand = 64'(root | bit_mask);
      if (cand * cand <= rad) begin
        root = root | bit_mask;
      end
      bit_mask = bit_mask >> 1;
    end
    return {{(distance_pkg::data_width-root_bits){1'b0}}, root};
  endfunction

  function automatic logic [distance_pkg::msg_width-1:0] make_pair(
    input logic [distance_pkg::data_width-1:0] a,
    input logic [distance_pkg::data_width-1:0] b
  );
    return {a, b};
  endfunction

  // ========================================
  // checks
  // ========================================
  task automatic check_distance(
    input string                               name,
    input logic [distance_pkg::data_width-1:0] expected,
    input logic [distance_pkg::data_width-1:0] actual
  );
    if (actual !== expected) begin
      mismatch_errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      mismatch_errors++;
      $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_idle();
    if (send_val && expected_q.size() == 0) begin
      other_errors++;
      $display("output valid at %0t with no job outstanding", $time);
    end
    if (accepted_count == 0 && recv_rdy !== 1'b1) begin
      other_errors++;
      $display("recv_rdy not high at %0t before the first job", $time);
    end
  endtask

  task automatic print_summary();
    $display("errors: %0d value mismatches, %0d other failures, %0d jobs in, %0d out",
             mismatch_errors, other_errors, accepted_count, received_count);
  endtask

  // ========================================
  // stimulus
  // ========================================
  task automatic wait_drive_point();
    @(posedge clk);
    #2;
  endtask

  task automatic send_job(
    input logic [distance_pkg::msg_width-1:0]  pair,
    input logic [distance_pkg::data_width-1:0] expected,
    input string                               name
  );
    int start;
    start = accepted_count;
    recv_msg         = pair;
    recv_val         = 1'b1;
    pending_expected = expected;
    pending_name     = name;
    while (accepted_count == start) begin
      wait_drive_point();
    end
    recv_val = 1'b0;
  endtask

  task automatic send_random_jobs(input int count, input logic [31:0] mask, input string name);
    logic [distance_pkg::msg_width-1:0] pair;
    repeat (count) begin
      pair = make_pair($urandom & mask, $urandom & mask);
      send_job(pair, model_distance(pair), name);
    end
  endtask

  // consumer side; long low stretches fill the queue
  task automatic drive_ready();
    int stretch;
    forever begin
      if (stall_mode) begin
        send_rdy = 1'b0;
        stretch = $urandom_range(400, 100);
        repeat (stretch) wait_drive_point();
        send_rdy = 1'b1;
        stretch = $urandom_range(8, 1);
        repeat (stretch) wait_drive_point();
      end else begin
        send_rdy = ($urandom_range(3, 0) != 0);
        wait_drive_point();
      end
    end
  endtask

  // ========================================
  // monitor
  // ========================================
  always @(negedge clk) begin
    if (!reset) begin
      check_idle();
      if (expected_q.size() > max_outstanding) begin
        max_outstanding = expected_q.size();
      end
      // four in the FIFO plus one in the root stage
      if (expected_q.size() >= distance_pkg::fifo_depth + 1 && recv_rdy) begin
        other_errors++;
        $display("recv_rdy high at %0t while queue and root stage are full", $time);
      end
      if (send_val && send_rdy) begin
        received_count++;
        if (expected_q.size() != 0) begin
          check_distance(name_q.pop_front(), expected_q.pop_front(), send_msg);
        end
      end
      if (recv_val && recv_rdy) begin
        expected_q.push_back(pending_expected);
        name_q.push_back(pending_name);
        accepted_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      print_summary();
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ========================================
  // test sequence
  // ========================================
  initial begin
    void'($urandom(32'hc4f0_65d4));
    recv_msg         = '0;
    recv_val         = 1'b0;
    send_rdy         = 1'b0;
    pending_expected = '0;
    pending_name     = "none";
    accepted_count   = 0;
    received_count   = 0;
    max_outstanding  = 0;
    mismatch_errors  = 0;
    other_errors     = 0;
    cycle_count      = 0;
    stall_mode       = 1'b0;
    fork
      drive_ready();
    join_none

    wait (reset == 1'b0);
    // idle cycles after reset; check_idle watches recv_rdy and send_val
    repeat (20) wait_drive_point();

    send_job(make_pair(32'h0003_0000, 32'h0004_0000), 32'h0005_0000, "exact 3 4");
    send_job(make_pair(32'h0000_0000, 32'h0000_0000), 32'h0000_0000, "exact zero");
    send_job(make_pair(32'h0001_0000, 32'h0000_0000), 32'h0001_0000, "exact one");
    send_job(make_pair(32'h0000_8000, 32'h0000_8000), 32'h0000_b504, "exact half");

    send_random_jobs(200, 32'h007f_ffff, "random range");
    send_random_jobs(50, 32'hffff_ffff, "wraparound");

    stall_mode = 1'b1;
    send_random_jobs(bp_jobs, 32'h00ff_ffff, "back-pressure");
    stall_mode = 1'b0;

    repeat (idle_jobs) begin
      repeat ($urandom_range(30, 0)) wait_drive_point();
      send_random_jobs(1, 32'hffff_ffff, "idle gaps");
    end

    while (expected_q.size() != 0) begin
      wait_drive_point();
    end
    // no stray results may follow the last one
    repeat (100) wait_drive_point();

    check_count("output count", accepted_count, received_count);
    if (max_outstanding < distance_pkg::fifo_depth + 1) begin
      other_errors++;
      $display("back-pressure never filled both the queue and the root stage");
    end

    print_summary();
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
